// File: source/rv_pkg.sv
package rv_pkg;

  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int ALU_OP_W = 5;
  localparam int FWD_W    = 2;

  // major opcodes handled by the core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra, srai
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  localparam logic [2:0] F3_ADD    = 3'd0;
  localparam logic [2:0] F3_SLL    = 3'd1;
  localparam logic [2:0] F3_SLT    = 3'd2;
  localparam logic [2:0] F3_SLTU   = 3'd3;
  localparam logic [2:0] F3_XOR    = 3'd4;
  localparam logic [2:0] F3_SR     = 3'd5; // srl or sra by funct7
  localparam logic [2:0] F3_OR     = 3'd6;
  localparam logic [2:0] F3_AND    = 3'd7;
  localparam logic [2:0] F3_MUL    = 3'd0;
  localparam logic [2:0] F3_MULH   = 3'd1;
  localparam logic [2:0] F3_MULHSU = 3'd2;
  localparam logic [2:0] F3_MULHU  = 3'd3;

  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 5'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 5'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 5'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 5'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 5'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 5'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 5'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 5'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 5'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 5'd9;
  localparam logic [ALU_OP_W-1:0] ALU_MUL    = 5'd10;
  localparam logic [ALU_OP_W-1:0] ALU_MULH   = 5'd11;
  localparam logic [ALU_OP_W-1:0] ALU_MULHSU = 5'd12;
  localparam logic [ALU_OP_W-1:0] ALU_MULHU  = 5'd13;

  // operand source for execute
  localparam logic [FWD_W-1:0] FWD_REG = 2'd0;
  localparam logic [FWD_W-1:0] FWD_EX  = 2'd1;
  localparam logic [FWD_W-1:0] FWD_WB  = 2'd2;

  typedef union packed {
    struct packed {
      logic [6:0]        funct7;
      logic [REG_AW-1:0] rs2;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } r_fmt;
    struct packed {
      logic [11:0]       imm12;
      logic [REG_AW-1:0] rs1;
      logic [2:0]        funct3;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } i_fmt;
    struct packed {
      logic [19:0]       imm20;
      logic [REG_AW-1:0] rd;
      logic [6:0]        opcode;
    } u_fmt;
  } instr_u;

endpackage

// File: source/decode_if.sv
`timescale 1ns/1ns

interface decode_if;

  logic                        valid;
  logic [rv_pkg::ALU_OP_W-1:0] alu_op;
  logic [rv_pkg::REG_AW-1:0]   rd;
  logic [rv_pkg::REG_AW-1:0]   rs1;
  logic [rv_pkg::REG_AW-1:0]   rs2;
  logic [rv_pkg::XLEN-1:0]     rs1_val; // as read in decode, before forwarding
  logic [rv_pkg::XLEN-1:0]     rs2_val;
  logic [rv_pkg::XLEN-1:0]     imm;
  logic                        use_imm;
  logic                        use_pc; // auipc
  logic [rv_pkg::XLEN-1:0]     pc; // word index

  modport producer (output valid, alu_op, rd, rs1, rs2, rs1_val, rs2_val, imm,
                    use_imm, use_pc, pc);
  modport consumer (input valid, alu_op, rd, rs1_val, rs2_val, imm, use_imm, use_pc, pc);
  modport monitor (input valid, rs1, rs2);

endinterface

// File: source/prog_mem.sv
`timescale 1ns/1ns

module prog_mem #(
  parameter int PROG_DEPTH = 256,
  localparam int AW = $clog2(PROG_DEPTH)
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load_valid,
  input  logic [rv_pkg::XLEN-1:0] load_word,
  input  logic                    fetch_valid,
  input  logic [AW-1:0]           fetch_pc,
  output rv_pkg::instr_u          instr,
  output logic                    instr_valid,
  output logic [AW:0]             word_count
);

  logic [rv_pkg::XLEN-1:0] mem [PROG_DEPTH];
  logic [AW:0]             wptr;    // next load slot
  logic [AW-1:0]           raddr_q;
  logic                    load_ok;

  assign load_ok = load_valid && (wptr < PROG_DEPTH); // ignore loads once full

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wptr        <= '0;
      instr_valid <= 1'b0;
    end
    else
    begin
      instr_valid <= fetch_valid;
      if (load_ok)
        wptr <= wptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load_ok)
      mem[wptr[AW-1:0]] <= load_word;
    raddr_q <= fetch_pc; // registered read address
  end

  assign instr      = mem[raddr_q];
  assign word_count = wptr;

endmodule

// File: source/decode_unit.sv
`timescale 1ns/1ns

module decode_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  rv_pkg::instr_u            instr,
  input  logic                      instr_valid,
  input  logic [rv_pkg::XLEN-1:0]   pc_in,
  output logic [rv_pkg::REG_AW-1:0] rs1_addr,
  output logic [rv_pkg::REG_AW-1:0] rs2_addr,
  input  logic [rv_pkg::XLEN-1:0]   rs1_data,
  input  logic [rv_pkg::XLEN-1:0]   rs2_data,
  decode_if.producer                dec
);

  logic [6:0]                  opcode;
  logic [2:0]                  funct3;
  logic [6:0]                  funct7;
  logic [rv_pkg::XLEN-1:0]     imm_i;
  logic [rv_pkg::XLEN-1:0]     imm_u;
  logic [rv_pkg::XLEN-1:0]     imm_sh;
  logic                        supported;
  logic [rv_pkg::ALU_OP_W-1:0] alu_op;
  logic [rv_pkg::XLEN-1:0]     imm;
  logic                        use_imm;
  logic                        use_pc;

  // funct3 to operation for the plain alu group
  function automatic logic [rv_pkg::ALU_OP_W-1:0] base_op(input logic [2:0] f3);
    case (f3)
      rv_pkg::F3_SLL:  return rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  return rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: return rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  return rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:   return rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:   return rv_pkg::ALU_OR;
      rv_pkg::F3_AND:  return rv_pkg::ALU_AND;
      default:         return rv_pkg::ALU_ADD;
    endcase
  endfunction

  assign opcode = instr.r_fmt.opcode;
  assign funct3 = instr.i_fmt.funct3;
  assign funct7 = instr.r_fmt.funct7;
  assign imm_i  = {{(rv_pkg::XLEN-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
  assign imm_u  = {instr.u_fmt.imm20, 12'd0};
  assign imm_sh = {{(rv_pkg::XLEN-rv_pkg::REG_AW){1'b0}}, instr.r_fmt.rs2}; // shamt

  // lui reads x0 so the add sees a zero operand
  assign rs1_addr = (opcode == rv_pkg::OPC_LUI) ? '0 : instr.r_fmt.rs1;
  assign rs2_addr = instr.r_fmt.rs2;

  always_comb
  begin
    supported = 1'b1;
    alu_op    = base_op(funct3);
    imm       = imm_i;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    case (opcode)
      rv_pkg::OPC_OP:
      begin
        if (funct7 == rv_pkg::F7_ALT && funct3 == rv_pkg::F3_ADD)
          alu_op = rv_pkg::ALU_SUB;
        else if (funct7 == rv_pkg::F7_ALT && funct3 == rv_pkg::F3_SR)
          alu_op = rv_pkg::ALU_SRA;
        else if (funct7 == rv_pkg::F7_MULDIV)
        begin
          case (funct3)
            rv_pkg::F3_MUL:    alu_op = rv_pkg::ALU_MUL;
            rv_pkg::F3_MULH:   alu_op = rv_pkg::ALU_MULH;
            rv_pkg::F3_MULHSU: alu_op = rv_pkg::ALU_MULHSU;
            rv_pkg::F3_MULHU:  alu_op = rv_pkg::ALU_MULHU;
            default:           supported = 1'b0; // div and rem
          endcase
        end
        else if (funct7 != rv_pkg::F7_BASE)
          supported = 1'b0;
      end
      rv_pkg::OPC_OP_IMM:
      begin
        use_imm = 1'b1;
        if (funct3 == rv_pkg::F3_SLL)
        begin
          imm       = imm_sh;
          supported = (funct7 == rv_pkg::F7_BASE);
        end
        else if (funct3 == rv_pkg::F3_SR)
        begin
          imm       = imm_sh;
          alu_op    = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
          supported = (funct7 == rv_pkg::F7_BASE) || (funct7 == rv_pkg::F7_ALT);
        end
      end
      rv_pkg::OPC_LUI:
      begin
        alu_op  = rv_pkg::ALU_ADD;
        imm     = imm_u;
        use_imm = 1'b1;
      end
      rv_pkg::OPC_AUIPC:
      begin
        alu_op  = rv_pkg::ALU_ADD;
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
      end
      default: supported = 1'b0; // bubble
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      dec.valid <= 1'b0;
    else
      dec.valid <= instr_valid && supported && (instr.u_fmt.rd != '0);
  end

  always_ff @(posedge clk)
  begin
    dec.alu_op  <= alu_op;
    dec.rd      <= instr.u_fmt.rd;
    dec.rs1     <= rs1_addr;
    dec.rs2     <= rs2_addr;
    dec.rs1_val <= rs1_data;
    dec.rs2_val <= rs2_data;
    dec.imm     <= imm;
    dec.use_imm <= use_imm;
    dec.use_pc  <= use_pc;
    dec.pc      <= pc_in;
  end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ns

module reg_file (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [rv_pkg::REG_AW-1:0] rs1_addr,
  input  logic [rv_pkg::REG_AW-1:0] rs2_addr,
  output logic [rv_pkg::XLEN-1:0]   rs1_data,
  output logic [rv_pkg::XLEN-1:0]   rs2_data,
  input  logic                      wr_en,
  input  logic [rv_pkg::REG_AW-1:0] wr_addr,
  input  logic [rv_pkg::XLEN-1:0]   wr_data
);

  logic [rv_pkg::XLEN-1:0] regs [1:31]; // x0 has no storage

  function automatic logic [rv_pkg::XLEN-1:0] rd_port(input logic [rv_pkg::REG_AW-1:0] addr);
    if (addr == '0)
      return '0;
    if (wr_en && wr_addr == addr)
      return wr_data; // same-cycle write wins
    return regs[addr];
  endfunction

  always_comb
  begin
    rs1_data = rd_port(rs1_addr);
    rs2_data = rd_port(rs2_addr);
  end

  always_ff @(posedge clk)
  begin
    if (wr_en && wr_addr != '0)
      regs[wr_addr] <= wr_data;
  end

  // decode drops rd of zero, so write-back never targets x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (rst) wr_en |-> wr_addr != '0)
    else $error("register write to x0");

endmodule

// File: source/alu_stage.sv
`timescale 1ns/1ns

module alu_stage (
  input  logic                      clk,
  input  logic                      rst,
  decode_if.consumer                dec,
  input  logic [rv_pkg::FWD_W-1:0]  fwd_a,
  input  logic [rv_pkg::FWD_W-1:0]  fwd_b,
  output logic                      ex_valid,
  output logic [rv_pkg::REG_AW-1:0] ex_rd,
  output logic                      wb_valid,
  output logic [rv_pkg::REG_AW-1:0] wb_rd,
  output logic [rv_pkg::XLEN-1:0]   wb_value
);

  logic [rv_pkg::XLEN-1:0] ex_value;
  logic [rv_pkg::XLEN-1:0] src_a;
  logic [rv_pkg::XLEN-1:0] src_b;
  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;
  logic signed [63:0]      prod_ss;
  logic signed [63:0]      prod_su;
  logic [63:0]             prod_uu;
  logic [rv_pkg::XLEN-1:0] alu_res;

  function automatic logic [rv_pkg::XLEN-1:0] pick(input logic [rv_pkg::FWD_W-1:0] sel,
                                                   input logic [rv_pkg::XLEN-1:0] reg_val,
                                                   input logic [rv_pkg::XLEN-1:0] ex_val,
                                                   input logic [rv_pkg::XLEN-1:0] wb_val);
    case (sel)
      rv_pkg::FWD_EX: return ex_val;
      rv_pkg::FWD_WB: return wb_val;
      default:        return reg_val;
    endcase
  endfunction

  assign src_a = pick(fwd_a, dec.rs1_val, ex_value, wb_value);
  assign src_b = pick(fwd_b, dec.rs2_val, ex_value, wb_value);
  assign op_a  = dec.use_pc ? dec.pc : src_a;
  assign op_b  = dec.use_imm ? dec.imm : src_b;
  assign shamt = op_b[4:0];

  // 64-bit products for the high multiplies
  assign prod_ss = $signed({{32{op_a[31]}}, op_a}) * $signed({{32{op_b[31]}}, op_b});
  assign prod_su = $signed({{32{op_a[31]}}, op_a}) * $signed({32'd0, op_b});
  assign prod_uu = {32'd0, op_a} * {32'd0, op_b};

  always_comb
  begin
    case (dec.alu_op)
      rv_pkg::ALU_ADD:    alu_res = op_a + op_b;
      rv_pkg::ALU_SUB:    alu_res = op_a - op_b;
      rv_pkg::ALU_SLL:    alu_res = op_a << shamt;
      rv_pkg::ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU:   alu_res = {31'd0, op_a < op_b};
      rv_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
      rv_pkg::ALU_SRL:    alu_res = op_a >> shamt;
      rv_pkg::ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
      rv_pkg::ALU_OR:     alu_res = op_a | op_b;
      rv_pkg::ALU_AND:    alu_res = op_a & op_b;
      rv_pkg::ALU_MUL:    alu_res = prod_uu[31:0];
      rv_pkg::ALU_MULH:   alu_res = prod_ss[63:32];
      rv_pkg::ALU_MULHSU: alu_res = prod_su[63:32];
      rv_pkg::ALU_MULHU:  alu_res = prod_uu[63:32];
      default:            alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end
    else
    begin
      ex_valid <= dec.valid;
      wb_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    ex_rd    <= dec.rd;
    ex_value <= alu_res;
    wb_rd    <= ex_rd; // write-back copy that also feeds the retire port
    wb_value <= ex_value;
  end

endmodule

// File: source/core_control.sv
`timescale 1ns/1ns

module core_control #(
  parameter int PROG_DEPTH = 256,
  localparam int AW = $clog2(PROG_DEPTH)
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic                      load_valid,
  input  logic [AW:0]               word_count,
  output logic                      fetch_valid,
  output logic [AW-1:0]             fetch_pc,
  decode_if.monitor                 dec,
  input  logic                      ex_valid,
  input  logic [rv_pkg::REG_AW-1:0] ex_rd,
  input  logic                      wb_valid,
  input  logic [rv_pkg::REG_AW-1:0] wb_rd,
  output logic [rv_pkg::FWD_W-1:0]  fwd_a,
  output logic [rv_pkg::FWD_W-1:0]  fwd_b,
  output logic                      done
);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_RUN   = 2'd1;
  localparam logic [1:0] ST_DRAIN = 2'd2;

  logic [1:0]    state;
  logic [AW-1:0] pc;
  logic [2:0]    inflight; // fetched words in memory read, decode, execute

  // youngest producer first
  function automatic logic [rv_pkg::FWD_W-1:0] fwd_sel(input logic [rv_pkg::REG_AW-1:0] rs);
    if (!dec.valid || rs == '0)
      return rv_pkg::FWD_REG;
    if (ex_valid && ex_rd == rs)
      return rv_pkg::FWD_EX;
    if (wb_valid && wb_rd == rs)
      return rv_pkg::FWD_WB;
    return rv_pkg::FWD_REG;
  endfunction

  always_comb
  begin
    fwd_a = fwd_sel(dec.rs1);
    fwd_b = fwd_sel(dec.rs2);
  end

  assign fetch_valid = (state == ST_RUN);
  assign fetch_pc    = pc;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= ST_IDLE;
      pc       <= '0;
      inflight <= '0;
      done     <= 1'b0;
    end
    else
    begin
      inflight <= {inflight[1:0], fetch_valid};
      case (state)
        ST_IDLE:
          if (start)
          begin
            pc    <= '0;
            done  <= 1'b0;
            state <= (word_count == '0) ? ST_DRAIN : ST_RUN;
          end
        ST_RUN:
        begin
          pc <= pc + 1'b1;
          if ({1'b0, pc} == word_count - 1'b1)
            state <= ST_DRAIN; // last word fetched
        end
        default:
          if (inflight == '0)
          begin
            state <= ST_IDLE; // last slot is in write-back now
            done  <= 1'b1;
          end
      endcase
    end
  end

  a_no_load_run: assert property (@(posedge clk) disable iff (rst)
    state != ST_IDLE |-> !load_valid) else $error("program load during a run");
  a_fetch_range: assert property (@(posedge clk) disable iff (rst)
    fetch_valid |-> {1'b0, fetch_pc} < word_count) else $error("fetch past loaded words");
  a_no_restart: assert property (@(posedge clk) disable iff (rst)
    state != ST_IDLE |-> !start) else $error("start during a run");

endmodule

// File: source/rv32_core_top.sv
`timescale 1ns/1ns

module rv32_core_top #(
  parameter int PROG_DEPTH = 256
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load_valid,
  input  logic [rv_pkg::XLEN-1:0]   load_word,
  input  logic                      start,
  output logic                      retire_valid,
  output logic [rv_pkg::REG_AW-1:0] retire_rd,
  output logic [rv_pkg::XLEN-1:0]   retire_value,
  output logic                      done
);

  localparam int AW = $clog2(PROG_DEPTH);

  logic [AW:0]               word_count;
  logic                      fetch_valid;
  logic [AW-1:0]             fetch_pc;
  logic [AW-1:0]             fetch_pc_q; // word index of the instruction in decode
  logic [rv_pkg::XLEN-1:0]   pc_in;
  rv_pkg::instr_u            instr;
  logic                      instr_valid;
  logic [rv_pkg::REG_AW-1:0] rs1_addr;
  logic [rv_pkg::REG_AW-1:0] rs2_addr;
  logic [rv_pkg::XLEN-1:0]   rs1_data;
  logic [rv_pkg::XLEN-1:0]   rs2_data;
  logic                      ex_valid;
  logic [rv_pkg::REG_AW-1:0] ex_rd;
  logic                      wb_valid;
  logic [rv_pkg::REG_AW-1:0] wb_rd;
  logic [rv_pkg::XLEN-1:0]   wb_value;
  logic [rv_pkg::FWD_W-1:0]  fwd_a;
  logic [rv_pkg::FWD_W-1:0]  fwd_b;

  decode_if dec_bus ();

  always_ff @(posedge clk)
  begin
    fetch_pc_q <= fetch_pc; // lines up with the registered memory read
  end

  assign pc_in = {{(rv_pkg::XLEN-AW){1'b0}}, fetch_pc_q};

  prog_mem #(.PROG_DEPTH(PROG_DEPTH)) u_prog_mem (
    .clk(clk), .rst(rst), .load_valid(load_valid), .load_word(load_word),
    .fetch_valid(fetch_valid), .fetch_pc(fetch_pc), .instr(instr),
    .instr_valid(instr_valid), .word_count(word_count)
  );

  core_control #(.PROG_DEPTH(PROG_DEPTH)) u_control (
    .clk(clk), .rst(rst), .start(start), .load_valid(load_valid),
    .word_count(word_count), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
    .dec(dec_bus.monitor), .ex_valid(ex_valid), .ex_rd(ex_rd), .wb_valid(wb_valid),
    .wb_rd(wb_rd), .fwd_a(fwd_a), .fwd_b(fwd_b), .done(done)
  );

  decode_unit u_decode (
    .clk(clk), .rst(rst), .instr(instr), .instr_valid(instr_valid), .pc_in(pc_in),
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_data(rs1_data),
    .rs2_data(rs2_data), .dec(dec_bus.producer)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .wr_en(wb_valid),
    .wr_addr(wb_rd), .wr_data(wb_value)
  );

  alu_stage u_alu (
    .clk(clk), .rst(rst), .dec(dec_bus.consumer), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .ex_valid(ex_valid), .ex_rd(ex_rd), .wb_valid(wb_valid), .wb_rd(wb_rd),
    .wb_value(wb_value)
  );

  // the write-back register is the retire port
  assign retire_valid = wb_valid;
  assign retire_rd    = wb_rd;
  assign retire_value = wb_value;

endmodule

// File: test/rv32_core_tb.sv
`timescale 1ns/1ns

module rv32_core_tb;

  typedef logic [rv_pkg::XLEN-1:0] reg_arr_t [32];

  logic                      clk;
  logic                      rst;
  logic                      load_valid;
  logic [rv_pkg::XLEN-1:0]   load_word;
  logic                      start;
  logic                      retire_valid;
  logic [rv_pkg::REG_AW-1:0] retire_rd;
  logic [rv_pkg::XLEN-1:0]   retire_value;
  logic                      done;

  logic [31:0]               lcg_state;
  reg_arr_t                  model_regs; // architectural state seen by the model
  logic [rv_pkg::XLEN-1:0]   prog [$];
  logic [rv_pkg::REG_AW-1:0] exp_rd_q [$];
  logic [rv_pkg::XLEN-1:0]   exp_val_q [$];
  string                     test_name;
  int                        retire_count;

  rv32_core_top #(.PROG_DEPTH(256)) DUT (
    .clk(clk), .rst(rst), .load_valid(load_valid), .load_word(load_word),
    .start(start), .retire_valid(retire_valid), .retire_rd(retire_rd),
    .retire_value(retire_value), .done(done)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_below(input logic [31:0] n);
    return (lcg_next() >> 8) % n; // low lcg bits are weak
  endfunction

  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd,
                                              input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] r_alu_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
    logic [31:0] sel;
    logic [6:0]  f7;
    logic [2:0]  f3;
    sel = rand_below(10);
    f3  = 3'(sel);
    f7  = rv_pkg::F7_BASE;
    if (sel == 8)
    begin
      f3 = rv_pkg::F3_ADD; // sub
      f7 = rv_pkg::F7_ALT;
    end
    else if (sel == 9)
    begin
      f3 = rv_pkg::F3_SR; // sra
      f7 = rv_pkg::F7_ALT;
    end
    return r_type_word(f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP);
  endfunction

  function automatic logic [31:0] i_alu_instr(input logic [4:0] rd, input logic [4:0] rs1);
    logic [11:0] imm;
    logic [2:0]  f3;
    logic [4:0]  shamt;
    imm   = 12'(rand_below(4096));
    shamt = 5'(rand_below(32));
    case (rand_below(9))
      0: f3 = rv_pkg::F3_ADD;
      1: f3 = rv_pkg::F3_SLT;
      2: f3 = rv_pkg::F3_SLTU;
      3: f3 = rv_pkg::F3_XOR;
      4: f3 = rv_pkg::F3_OR;
      5: f3 = rv_pkg::F3_AND;
      6:
      begin
        f3  = rv_pkg::F3_SLL;
        imm = {rv_pkg::F7_BASE, shamt};
      end
      7:
      begin
        f3  = rv_pkg::F3_SR;
        imm = {rv_pkg::F7_BASE, shamt};
      end
      default:
      begin
        f3  = rv_pkg::F3_SR;
        imm = {rv_pkg::F7_ALT, shamt}; // srai
      end
    endcase
    return i_type_word(imm, rs1, f3, rd, rv_pkg::OPC_OP_IMM);
  endfunction

  function automatic logic [31:0] mixed_alu_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                                  input logic [4:0] rs2);
    if (rand_below(2) == 0)
      return r_alu_instr(rd, rs1, rs2);
    return i_alu_instr(rd, rs1);
  endfunction

  // reference model with idx as the word index for auipc
  function automatic logic exec_instr(input rv_pkg::instr_u ins, input int idx,
                                      input reg_arr_t regs,
                                      output logic [rv_pkg::REG_AW-1:0] rd,
                                      output logic [rv_pkg::XLEN-1:0] val);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [63:0] prod;
    logic        ok;
    a   = regs[ins.r_fmt.rs1];
    b   = regs[ins.r_fmt.rs2];
    imm = {{20{ins.i_fmt.imm12[11]}}, ins.i_fmt.imm12};
    rd  = ins.u_fmt.rd;
    val = '0;
    ok  = 1'b1;
    case (ins.r_fmt.opcode)
      rv_pkg::OPC_OP:
        case ({ins.r_fmt.funct7, ins.r_fmt.funct3})
          {7'h00, 3'd0}: val = a + b;
          {7'h20, 3'd0}: val = a - b;
          {7'h00, 3'd1}: val = a << b[4:0];
          {7'h00, 3'd2}: val = {31'd0, $signed(a) < $signed(b)};
          {7'h00, 3'd3}: val = {31'd0, a < b};
          {7'h00, 3'd4}: val = a ^ b;
          {7'h00, 3'd5}: val = a >> b[4:0];
          {7'h20, 3'd5}: val = $signed(a) >>> b[4:0];
          {7'h00, 3'd6}: val = a | b;
          {7'h00, 3'd7}: val = a & b;
          {7'h01, 3'd0}:
          begin
            prod = {32'd0, a} * {32'd0, b};
            val  = prod[31:0];
          end
          {7'h01, 3'd1}:
          begin
            prod = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // mod 2^64 equals signed product
            val  = prod[63:32];
          end
          {7'h01, 3'd2}:
          begin
            prod = {{32{a[31]}}, a} * {32'd0, b};
            val  = prod[63:32];
          end
          {7'h01, 3'd3}:
          begin
            prod = {32'd0, a} * {32'd0, b};
            val  = prod[63:32];
          end
          default: ok = 1'b0;
        endcase
      rv_pkg::OPC_OP_IMM:
        case (ins.i_fmt.funct3)
          3'd0: val = a + imm;
          3'd2: val = {31'd0, $signed(a) < $signed(imm)};
          3'd3: val = {31'd0, a < imm};
          3'd4: val = a ^ imm;
          3'd6: val = a | imm;
          3'd7: val = a & imm;
          3'd1:
            if (ins.r_fmt.funct7 == 7'h00)
              val = a << ins.r_fmt.rs2;
            else
              ok = 1'b0;
          default:
            if (ins.r_fmt.funct7 == 7'h00)
              val = a >> ins.r_fmt.rs2;
            else if (ins.r_fmt.funct7 == 7'h20)
              val = $signed(a) >>> ins.r_fmt.rs2;
            else
              ok = 1'b0;
        endcase
      rv_pkg::OPC_LUI:   val = {ins.u_fmt.imm20, 12'd0};
      rv_pkg::OPC_AUIPC: val = 32'(idx) + {ins.u_fmt.imm20, 12'd0};
      default:           ok = 1'b0;
    endcase
    return ok && (rd != '0);
  endfunction

  task automatic check_rd(input string name, input logic [rv_pkg::REG_AW-1:0] exp,
                          input logic [rv_pkg::REG_AW-1:0] act);
    if (act !== exp)
    begin
      $display("Fail %s rd expected x%0d actual x%0d", name, exp, act);
      $display("Checks failed");
      $fatal(1, "retire register mismatch");
    end
  endtask

  task automatic check_value(input string name, input logic [rv_pkg::XLEN-1:0] exp,
                             input logic [rv_pkg::XLEN-1:0] act);
    if (act !== exp)
    begin
      $display("Fail %s value expected %h actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1, "retire value mismatch");
    end
  endtask

  // outputs settle after posedge, so sample on negedge
  always @(negedge clk)
  begin : compare_retire
    logic [rv_pkg::REG_AW-1:0] exp_rd;
    logic [rv_pkg::XLEN-1:0]   exp_val;
    string                     name;
    if (retire_valid === 1'b1)
    begin
      if (done === 1'b1)
      begin
        $display("retirement of x%0d in %s while done is high", retire_rd, test_name);
        $display("Checks failed");
        $fatal(1, "retirement while done");
      end
      else if (exp_rd_q.size() == 0)
      begin
        $display("retirement of x%0d in %s when none was expected", retire_rd, test_name);
        $display("Checks failed");
        $fatal(1, "unexpected retirement");
      end
      else
      begin
        exp_rd  = exp_rd_q.pop_front();
        exp_val = exp_val_q.pop_front();
        name    = $sformatf("%s retire %0d", test_name, retire_count);
        check_rd(name, exp_rd, retire_rd);
        check_value(name, exp_val, retire_value);
        retire_count++;
      end
    end
  end

  task automatic reset_dut();
    rst = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (done !== 1'b0 || retire_valid !== 1'b0)
    begin
      $display("done or retire_valid not low after reset");
      $display("Checks failed");
      $fatal(1, "bad reset state");
    end
    prog.delete();
  endtask

  task automatic load_program();
    foreach (prog[i])
    begin
      @(negedge clk);
      load_valid = 1'b1;
      load_word  = prog[i];
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int cycles;
    cycles = 0;
    while (done !== 1'b1 && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1)
    begin
      $display("timeout, done not seen within %0d cycles in %s", limit, test_name);
      $display("Checks failed");
      $fatal(1, "timeout waiting for done");
    end
  endtask

  // model the whole program first, then start and wait
  task automatic run_program(input string name);
    logic [rv_pkg::REG_AW-1:0] rd;
    logic [rv_pkg::XLEN-1:0]   val;
    test_name = name;
    foreach (prog[i])
    begin
      if (exec_instr(prog[i], i, model_regs, rd, val))
      begin
        exp_rd_q.push_back(rd);
        exp_val_q.push_back(val);
        model_regs[rd] = val;
      end
    end
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_done(prog.size() + 16);
    if (exp_rd_q.size() != 0)
    begin
      $display("%0d expected retirements missing at done in %s", exp_rd_q.size(), name);
      $display("Checks failed");
      $fatal(1, "missing retirements");
    end
  endtask

  // lui plus addi with the upper part rounded for the signed low half
  task automatic set_reg_words(input logic [4:0] r, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    prog.push_back(u_type_word(hi[31:12], r, rv_pkg::OPC_LUI));
    prog.push_back(i_type_word(v[11:0], r, rv_pkg::F3_ADD, r, rv_pkg::OPC_OP_IMM));
  endtask

  task automatic build_random_mix();
    for (int i = 0; i < 48; i++)
      prog.push_back(mixed_alu_instr(5'(16 + rand_below(16)), 5'(1 + rand_below(15)),
                                     5'(1 + rand_below(15))));
  endtask

  task automatic build_chains();
    logic [4:0] src;
    int         gap;
    for (int rep = 0; rep < 16; rep++)
    begin
      gap = rep % 4 + 1;
      src = 5'(1 + rand_below(15));
      prog.push_back(mixed_alu_instr(src, 5'(16 + rand_below(16)), 5'(16 + rand_below(16))));
      for (int f = 1; f < gap; f++)
        prog.push_back(mixed_alu_instr(5'(16 + rand_below(16)), 5'(16 + rand_below(16)),
                                       5'(16 + rand_below(16))));
      if (rep < 8)
        prog.push_back(mixed_alu_instr(5'(16 + rand_below(16)), src, 5'(16 + rand_below(16))));
      else
        prog.push_back(r_alu_instr(5'(16 + rand_below(16)), 5'(16 + rand_below(16)), src));
    end
  endtask

  task automatic build_mul();
    logic [31:0] ops [8];
    ops[0] = 32'h8000_0000;
    ops[1] = 32'h7fff_ffff;
    ops[2] = 32'hffff_ffff;
    ops[3] = 32'h0000_0001;
    ops[4] = 32'hffff_8001;
    ops[5] = 32'h0000_ffff;
    ops[6] = lcg_next();
    ops[7] = lcg_next();
    for (int i = 0; i < 8; i++)
      set_reg_words(5'(i + 1), ops[i]);
    for (int op = 0; op < 4; op++)
      for (int i = 0; i < 8; i++)
        prog.push_back(r_type_word(rv_pkg::F7_MULDIV, 5'((i * 3 + op) % 8 + 1), 5'(i + 1),
                                   3'(op), 5'(16 + rand_below(16)), rv_pkg::OPC_OP));
  endtask

  task automatic build_bubbles();
    prog.push_back(r_type_word(rv_pkg::F7_BASE, 5'd6, 5'd5, rv_pkg::F3_ADD, 5'd0,
                               rv_pkg::OPC_OP)); // rd of zero
    prog.push_back(i_type_word(12'h07b, 5'd1, rv_pkg::F3_ADD, 5'd0, rv_pkg::OPC_OP_IMM));
    prog.push_back(r_type_word(rv_pkg::F7_BASE, 5'd1, 5'd0, rv_pkg::F3_ADD, 5'd9,
                               rv_pkg::OPC_OP));
    prog.push_back({7'h12, 5'd3, 5'd4, 3'b010, 5'd9, 7'b0100011}); // sw
    prog.push_back({12'h004, 5'd2, 3'b000, 5'd10, 7'b1100111});    // jalr
    prog.push_back(r_type_word(rv_pkg::F7_MULDIV, 5'd2, 5'd1, 3'd4, 5'd11, rv_pkg::OPC_OP));
    prog.push_back(r_type_word(7'h10, 5'd2, 5'd1, rv_pkg::F3_ADD, 5'd12, rv_pkg::OPC_OP));
    prog.push_back(32'd0);
    prog.push_back(i_type_word(12'h000, 5'd0, rv_pkg::F3_OR, 5'd13, rv_pkg::OPC_OP_IMM));
    prog.push_back(r_type_word(rv_pkg::F7_BASE, 5'd0, 5'd0, rv_pkg::F3_XOR, 5'd14,
                               rv_pkg::OPC_OP));
    for (int i = 0; i < 8; i++)
    begin
      prog.push_back(u_type_word(20'(lcg_next()), 5'(24 + i), rv_pkg::OPC_LUI));
      prog.push_back(u_type_word(20'(lcg_next()), 5'(16 + i), rv_pkg::OPC_AUIPC));
    end
    // x5 and x6 accumulate, so a rerun sees the old state
    prog.push_back(r_type_word(rv_pkg::F7_BASE, 5'd6, 5'd5, rv_pkg::F3_ADD, 5'd5,
                               rv_pkg::OPC_OP));
    prog.push_back(r_type_word(rv_pkg::F7_BASE, 5'd5, 5'd6, rv_pkg::F3_XOR, 5'd6,
                               rv_pkg::OPC_OP));
    prog.push_back(r_type_word(rv_pkg::F7_MULDIV, 5'd9, 5'd16, rv_pkg::F3_MULH, 5'd17,
                               rv_pkg::OPC_OP));
  endtask

  initial
  begin
    rst          = 1'b1;
    load_valid   = 1'b0;
    load_word    = '0;
    start        = 1'b0;
    retire_count = 0;
    test_name    = "reset";
    lcg_state    = 32'd55805;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;

    reset_dut();
    for (int r = 1; r < 32; r++)
      set_reg_words(5'(r), lcg_next()); // defined values in every register
    load_program();
    run_program("register init");

    reset_dut();
    build_random_mix();
    load_program();
    run_program("random mix");

    reset_dut();
    build_chains();
    load_program();
    run_program("forwarding chains");
    run_program("forwarding chains rerun");

    reset_dut();
    build_mul();
    load_program();
    run_program("multiply");

    reset_dut();
    build_bubbles();
    load_program();
    run_program("bubbles and upper immediates");
    run_program("second start");

    $display("All checks passed");
    $finish;
  end

endmodule

// File: vlog.f
source/rv_pkg.sv
source/decode_if.sv
source/prog_mem.sv
source/decode_unit.sv
source/reg_file.sv
source/alu_stage.sv
source/core_control.sv
source/rv32_core_top.sv
test/rv32_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f vlog.f --top-module rv32_core_tb \
       -o rv32_core_sim \
  && ./obj_dir/rv32_core_sim \
  || { echo "simulation failed"; exit 1; }
